// ==== Makefile ====
TOOL  = verilator
FLAGS = --binary --timing --assert
TOP   = game_core_tb
FLIST = flist.f
BUILD = obj_dir
LOG   = sim.log
PASS  = TEST PASS

.PHONY: help test clean

help:
	@echo "make help   list the targets"
	@echo "make test   build and run the testbench, then check the log"
	@echo "make clean  remove the build folder and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

// ==== flist.f ====
hdl/game_pkg.sv
hdl/vga_timing.sv
hdl/game_fsm.sv
hdl/draw_background.sv
hdl/obstacle_wave.sv
hdl/hp_control.sv
hdl/game_core.sv
verification/game_core_properties.sv
verification/game_core_tb.sv

// ==== hdl/draw_background.sv ====
/*
 * first pixel stage: screen, border, play area, start box
 */
`timescale 1ns/1ps

module draw_background #(
    parameter game_pkg::coord_t TOP_V_LINE    = 12'd317,
    parameter game_pkg::coord_t BOTTOM_V_LINE = 12'd617,
    parameter game_pkg::coord_t LEFT_H_LINE   = 12'd361,
    parameter game_pkg::coord_t RIGHT_H_LINE  = 12'd661,
    parameter game_pkg::coord_t BORDER        = 12'd7,
    parameter game_pkg::coord_t START_X       = 12'd432,
    parameter game_pkg::coord_t START_Y       = 12'd400,
    parameter game_pkg::coord_t START_W       = 12'd128,
    parameter game_pkg::coord_t START_H       = 12'd80
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  game_pkg::vga_sig_t    raster,
    input  game_pkg::game_state_e game_state,
    output game_pkg::vga_sig_t    bg_sig,
    output game_pkg::rgb_t        bg_rgb
);

    logic           in_play;
    logic           in_frame;
    logic           in_start;
    game_pkg::rgb_t pixel;

    assign in_play  = (raster.hcount >= LEFT_H_LINE) && (raster.hcount < RIGHT_H_LINE) &&
                      (raster.vcount >= TOP_V_LINE) && (raster.vcount < BOTTOM_V_LINE);
    // play area grown by the border width
    assign in_frame = (raster.hcount >= LEFT_H_LINE - BORDER) &&
                      (raster.hcount < RIGHT_H_LINE + BORDER) &&
                      (raster.vcount >= TOP_V_LINE - BORDER) &&
                      (raster.vcount < BOTTOM_V_LINE + BORDER);
    assign in_start = (raster.hcount >= START_X) && (raster.hcount < START_X + START_W) &&
                      (raster.vcount >= START_Y) && (raster.vcount < START_Y + START_H);

    always_comb begin
        if (raster.hblnk || raster.vblnk) begin
            pixel = '0;
        end else if (in_start && game_state == game_pkg::MENU) begin
            pixel = game_pkg::COLOR_START_BOX;
        end else if (in_play) begin
            case (game_state)
                game_pkg::MENU:      pixel = game_pkg::COLOR_MENU;
                game_pkg::PLAY:      pixel = game_pkg::COLOR_PLAY;
                game_pkg::GAME_OVER: pixel = game_pkg::COLOR_GAME_OVER;
                default:             pixel = game_pkg::COLOR_VICTORY;
            endcase
        end else if (in_frame) begin
            pixel = game_pkg::COLOR_BORDER;
        end else begin
            pixel = game_pkg::COLOR_SCREEN;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bg_sig <= '0;
            bg_rgb <= '0;
        end else begin
            bg_sig <= raster;
            bg_rgb <= pixel;
        end
    end

endmodule

// ==== hdl/game_core.sv ====
/*
 * dodge game core: timing, state machine, pixel stages
 * obstacle waves and hit points
 */
`timescale 1ns/1ps

module game_core #(
    parameter game_pkg::coord_t H_ACTIVE      = 12'd1024,
    parameter game_pkg::coord_t H_FRONT       = 12'd24,
    parameter game_pkg::coord_t H_SYNC        = 12'd136,
    parameter game_pkg::coord_t H_BACK        = 12'd160,
    parameter game_pkg::coord_t V_ACTIVE      = 12'd768,
    parameter game_pkg::coord_t V_FRONT       = 12'd3,
    parameter game_pkg::coord_t V_SYNC        = 12'd6,
    parameter game_pkg::coord_t V_BACK        = 12'd29,
    parameter game_pkg::coord_t TOP_V_LINE    = 12'd317,
    parameter game_pkg::coord_t BOTTOM_V_LINE = 12'd617,
    parameter game_pkg::coord_t LEFT_H_LINE   = 12'd361,
    parameter game_pkg::coord_t RIGHT_H_LINE  = 12'd661,
    parameter game_pkg::coord_t BORDER        = 12'd7,
    parameter game_pkg::coord_t START_X       = 12'd432,
    parameter game_pkg::coord_t START_Y       = 12'd400,
    parameter game_pkg::coord_t START_W       = 12'd128,
    parameter game_pkg::coord_t START_H       = 12'd80,
    parameter game_pkg::coord_t OBS_W         = 12'd64,
    parameter game_pkg::coord_t OBS_H         = 12'd40,
    parameter game_pkg::coord_t OBS_SPEED     = 12'd4,
    parameter logic [3:0]       NUM_WAVES     = 4'd8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  game_button,
    input  logic                  menu_button,
    input  logic                  game_over_button,
    input  logic                  mouse_left,
    input  game_pkg::point_t      cursor,
    output logic                  hsync,
    output logic                  vsync,
    output game_pkg::rgb_t        rgb_out,
    output game_pkg::game_state_e game_state,
    output game_pkg::hp_t         hp,
    output logic [3:0]            wave
);

    game_pkg::vga_sig_t raster;
    game_pkg::vga_sig_t bg_sig;
    game_pkg::rgb_t     bg_rgb;
    game_pkg::point_t   obstacle;
    logic               frame_tick;
    logic               waves_done;
    logic               hp_empty;

    vga_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) vga_timing_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .raster     (raster),
        .frame_tick (frame_tick)
    );

    game_fsm #(
        .START_X(START_X), .START_Y(START_Y), .START_W(START_W), .START_H(START_H)
    ) game_fsm_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .game_button      (game_button),
        .menu_button      (menu_button),
        .game_over_button (game_over_button),
        .mouse_left       (mouse_left),
        .hp_empty         (hp_empty),
        .waves_done       (waves_done),
        .cursor           (cursor),
        .game_state       (game_state)
    );

    draw_background #(
        .TOP_V_LINE(TOP_V_LINE), .BOTTOM_V_LINE(BOTTOM_V_LINE),
        .LEFT_H_LINE(LEFT_H_LINE), .RIGHT_H_LINE(RIGHT_H_LINE), .BORDER(BORDER),
        .START_X(START_X), .START_Y(START_Y), .START_W(START_W), .START_H(START_H)
    ) draw_background_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .raster     (raster),
        .game_state (game_state),
        .bg_sig     (bg_sig),
        .bg_rgb     (bg_rgb)
    );

    obstacle_wave #(
        .TOP_V_LINE(TOP_V_LINE), .LEFT_H_LINE(LEFT_H_LINE), .RIGHT_H_LINE(RIGHT_H_LINE),
        .OBS_W(OBS_W), .OBS_H(OBS_H), .OBS_SPEED(OBS_SPEED), .NUM_WAVES(NUM_WAVES)
    ) obstacle_wave_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .frame_tick (frame_tick),
        .game_state (game_state),
        .bg_sig     (bg_sig),
        .bg_rgb     (bg_rgb),
        .obstacle   (obstacle),
        .wave       (wave),
        .waves_done (waves_done),
        .hsync      (hsync),
        .vsync      (vsync),
        .rgb_out    (rgb_out)
    );

    hp_control #(
        .OBS_W(OBS_W), .OBS_H(OBS_H)
    ) hp_control_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .frame_tick (frame_tick),
        .game_state (game_state),
        .cursor     (cursor),
        .obstacle   (obstacle),
        .hp         (hp),
        .hp_empty   (hp_empty)
    );

endmodule

// ==== hdl/game_fsm.sv ====
/*
 * game state machine: menu, play, game over, victory
 * start-box hit test for the mouse click
 */
`timescale 1ns/1ps

module game_fsm #(
    parameter game_pkg::coord_t START_X = 12'd432,
    parameter game_pkg::coord_t START_Y = 12'd400,
    parameter game_pkg::coord_t START_W = 12'd128,
    parameter game_pkg::coord_t START_H = 12'd80
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  game_button,
    input  logic                  menu_button,
    input  logic                  game_over_button,
    input  logic                  mouse_left,
    input  logic                  hp_empty,
    input  logic                  waves_done,
    input  game_pkg::point_t      cursor,
    output game_pkg::game_state_e game_state
);

    game_pkg::game_state_e state_nxt;
    logic                  in_start;

    assign in_start = (cursor.x >= START_X) && (cursor.x < START_X + START_W) &&
                      (cursor.y >= START_Y) && (cursor.y < START_Y + START_H);

    always_comb begin
        state_nxt = game_state;
        case (game_state)
            game_pkg::MENU: begin
                if (game_button || (mouse_left && in_start)) begin
                    state_nxt = game_pkg::PLAY;
                end
            end
            game_pkg::PLAY: begin
                // losing wins over a last wave passing in the same cycle
                if (hp_empty || game_over_button) begin
                    state_nxt = game_pkg::GAME_OVER;
                end else if (waves_done) begin
                    state_nxt = game_pkg::VICTORY;
                end
            end
            default: begin
                state_nxt = game_state;
            end
        endcase
        // back to menu from anywhere
        if (menu_button) begin
            state_nxt = game_pkg::MENU;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            game_state <= game_pkg::MENU;
        end else begin
            game_state <= state_nxt;
        end
    end

endmodule

// ==== hdl/game_pkg.sv ====
/*
 * shared game types: raster bundle, screen point, state enum
 * colour constants, lane table and hit-point defaults
 */
package game_pkg;

    typedef logic [11:0] coord_t;
    typedef logic [11:0] rgb_t;
    typedef logic [1:0]  hp_t;

    typedef struct packed {
        coord_t hcount;
        coord_t vcount;
        logic   hsync;
        logic   vsync;
        logic   hblnk;
        logic   vblnk;
    } vga_sig_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } point_t;

    typedef enum logic [1:0] {
        MENU      = 2'd0,
        PLAY      = 2'd1,
        GAME_OVER = 2'd2,
        VICTORY   = 2'd3
    } game_state_e;

    localparam rgb_t COLOR_SCREEN    = 12'h2_2_2;
    localparam rgb_t COLOR_BORDER    = 12'hf_f_f;
    localparam rgb_t COLOR_PLAY      = 12'h0_0_4;
    localparam rgb_t COLOR_MENU      = 12'h0_4_4;
    localparam rgb_t COLOR_START_BOX = 12'h0_c_0;
    localparam rgb_t COLOR_OBSTACLE  = 12'hf_0_0;
    localparam rgb_t COLOR_GAME_OVER = 12'h6_0_0;
    localparam rgb_t COLOR_VICTORY   = 12'h0_6_0;

    localparam int NUM_LANES = 4;
    // lane tops, counted down from the upper play line
    localparam coord_t LANE_OFFSET [NUM_LANES] = '{12'd2, 12'd12, 12'd22, 12'd32};

    localparam hp_t START_HP = 2'd3;

endpackage

// ==== hdl/hp_control.sv ====
/*
 * cursor against obstacle once per frame
 * hit-point counter, held at start value in menu
 */
`timescale 1ns/1ps

module hp_control #(
    parameter game_pkg::coord_t OBS_W = 12'd64,
    parameter game_pkg::coord_t OBS_H = 12'd40
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  frame_tick,
    input  game_pkg::game_state_e game_state,
    input  game_pkg::point_t      cursor,
    input  game_pkg::point_t      obstacle,
    output game_pkg::hp_t         hp,
    output logic                  hp_empty
);

    logic hit;

    // same pixels as drawn, edges included
    assign hit = (cursor.x >= obstacle.x) && (cursor.x < obstacle.x + OBS_W) &&
                 (cursor.y >= obstacle.y) && (cursor.y < obstacle.y + OBS_H);

    assign hp_empty = (hp == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hp <= game_pkg::START_HP;
        end else if (game_state == game_pkg::MENU) begin
            hp <= game_pkg::START_HP;
        end else if (frame_tick && game_state == game_pkg::PLAY && hit && !hp_empty) begin
            // at most one point per frame
            hp <= hp - 2'd1;
        end
    end

endmodule

// ==== hdl/obstacle_wave.sv ====
/*
 * moving obstacle and wave counter
 * obstacle overlay as the last pixel stage
 */
`timescale 1ns/1ps

module obstacle_wave #(
    parameter game_pkg::coord_t TOP_V_LINE   = 12'd317,
    parameter game_pkg::coord_t LEFT_H_LINE  = 12'd361,
    parameter game_pkg::coord_t RIGHT_H_LINE = 12'd661,
    parameter game_pkg::coord_t OBS_W        = 12'd64,
    parameter game_pkg::coord_t OBS_H        = 12'd40,
    parameter game_pkg::coord_t OBS_SPEED    = 12'd4,
    parameter logic [3:0]       NUM_WAVES    = 4'd8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  frame_tick,
    input  game_pkg::game_state_e game_state,
    input  game_pkg::vga_sig_t    bg_sig,
    input  game_pkg::rgb_t        bg_rgb,
    output game_pkg::point_t      obstacle,
    output logic [3:0]            wave,
    output logic                  waves_done,
    output logic                  hsync,
    output logic                  vsync,
    output game_pkg::rgb_t        rgb_out
);

    localparam int LANE_BITS = $clog2(game_pkg::NUM_LANES);

    game_pkg::coord_t next_x;
    logic [3:0]       wave_next;
    logic             in_obs;
    game_pkg::rgb_t   pixel;

    assign next_x    = obstacle.x + OBS_SPEED;
    assign wave_next = wave + 4'd1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            obstacle.x <= LEFT_H_LINE;
            obstacle.y <= TOP_V_LINE + game_pkg::LANE_OFFSET[0];
            wave       <= '0;
        end else if (game_state == game_pkg::MENU) begin
            obstacle.x <= LEFT_H_LINE;
            obstacle.y <= TOP_V_LINE + game_pkg::LANE_OFFSET[0];
            wave       <= '0;
        end else if (frame_tick && game_state == game_pkg::PLAY) begin
            if (next_x + OBS_W > RIGHT_H_LINE) begin
                // wave passed, restart at the left in the next lane
                wave       <= wave_next;
                obstacle.x <= LEFT_H_LINE;
                obstacle.y <= TOP_V_LINE + game_pkg::LANE_OFFSET[wave_next[LANE_BITS-1:0]];
            end else begin
                obstacle.x <= next_x;
            end
        end
    end

    assign waves_done = (wave == NUM_WAVES);

    assign in_obs = (bg_sig.hcount >= obstacle.x) && (bg_sig.hcount < obstacle.x + OBS_W) &&
                    (bg_sig.vcount >= obstacle.y) && (bg_sig.vcount < obstacle.y + OBS_H);

    always_comb begin
        if (bg_sig.hblnk || bg_sig.vblnk) begin
            pixel = '0;
        end else if (in_obs && game_state == game_pkg::PLAY) begin
            pixel = game_pkg::COLOR_OBSTACLE;
        end else begin
            pixel = bg_rgb;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hsync   <= 1'b0;
            vsync   <= 1'b0;
            rgb_out <= '0;
        end else begin
            hsync   <= bg_sig.hsync;
            vsync   <= bg_sig.vsync;
            rgb_out <= pixel;
        end
    end

endmodule

// ==== hdl/vga_timing.sv ====
/*
 * raster counters with sync and blank decode
 * frame tick at the first line of vertical blank
 */
`timescale 1ns/1ps

module vga_timing #(
    parameter game_pkg::coord_t H_ACTIVE = 12'd1024,
    parameter game_pkg::coord_t H_FRONT  = 12'd24,
    parameter game_pkg::coord_t H_SYNC   = 12'd136,
    parameter game_pkg::coord_t H_BACK   = 12'd160,
    parameter game_pkg::coord_t V_ACTIVE = 12'd768,
    parameter game_pkg::coord_t V_FRONT  = 12'd3,
    parameter game_pkg::coord_t V_SYNC   = 12'd6,
    parameter game_pkg::coord_t V_BACK   = 12'd29
) (
    input  logic               clk,
    input  logic               rst_n,
    output game_pkg::vga_sig_t raster,
    output logic               frame_tick
);

    localparam game_pkg::coord_t H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam game_pkg::coord_t V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    game_pkg::coord_t hcount;
    game_pkg::coord_t vcount;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hcount <= '0;
            vcount <= '0;
        end else if (hcount == H_TOTAL - 12'd1) begin
            hcount <= '0;
            vcount <= (vcount == V_TOTAL - 12'd1) ? '0 : vcount + 12'd1;
        end else begin
            hcount <= hcount + 12'd1;
        end
    end

    always_comb begin
        raster.hcount = hcount;
        raster.vcount = vcount;
        raster.hsync  = (hcount >= H_ACTIVE + H_FRONT) && (hcount < H_ACTIVE + H_FRONT + H_SYNC);
        raster.vsync  = (vcount >= V_ACTIVE + V_FRONT) && (vcount < V_ACTIVE + V_FRONT + V_SYNC);
        raster.hblnk  = (hcount >= H_ACTIVE);
        raster.vblnk  = (vcount >= V_ACTIVE);
    end

    // one cycle, start of vertical blank
    assign frame_tick = (hcount == '0) && (vcount == V_ACTIVE);

endmodule

// ==== verification/game_core_properties.sv ====
/*
 * bound assertions on hit points, game-over entry and blank pixels
 * output raster rebuilt from the sync edges
 */
`timescale 1ns/1ps

module game_core_properties #(
    parameter game_pkg::coord_t H_ACTIVE = 12'd1024,
    parameter game_pkg::coord_t H_FRONT  = 12'd24,
    parameter game_pkg::coord_t H_SYNC   = 12'd136,
    parameter game_pkg::coord_t H_BACK   = 12'd160,
    parameter game_pkg::coord_t V_ACTIVE = 12'd768,
    parameter game_pkg::coord_t V_FRONT  = 12'd3,
    parameter game_pkg::coord_t V_SYNC   = 12'd6,
    parameter game_pkg::coord_t V_BACK   = 12'd29
) (
    input logic                  clk,
    input logic                  rst_n,
    input game_pkg::game_state_e game_state,
    input game_pkg::hp_t         hp,
    input logic                  hsync,
    input logic                  vsync,
    input game_pkg::rgb_t        rgb_out
);

    localparam game_pkg::coord_t H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam game_pkg::coord_t V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    game_pkg::coord_t h;
    game_pkg::coord_t v;
    game_pkg::coord_t h_nxt;
    logic             hsync_q;
    logic             vsync_q;
    logic             locked;

    // h and v track the pixel now on rgb_out
    assign h_nxt = (hsync && !hsync_q) ? H_ACTIVE + H_FRONT + 12'd1 :
                   (h == H_TOTAL - 12'd1) ? '0 : h + 12'd1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            h       <= '0;
            v       <= '0;
            hsync_q <= 1'b0;
            vsync_q <= 1'b0;
            locked  <= 1'b0;
        end else begin
            h       <= h_nxt;
            hsync_q <= hsync;
            vsync_q <= vsync;
            if (vsync && !vsync_q) begin
                v      <= V_ACTIVE + V_FRONT;
                locked <= 1'b1;
            end else if (h_nxt == '0) begin
                v <= (v == V_TOTAL - 12'd1) ? '0 : v + 12'd1;
            end
        end
    end

    hp_no_refill: assert property (@(posedge clk) disable iff (!rst_n)
        $past(game_state) != game_pkg::MENU |-> hp <= $past(hp))
        else $error("hit points rose outside the menu");

    game_over_entry: assert property (@(posedge clk) disable iff (!rst_n)
        (game_state == game_pkg::GAME_OVER && $past(game_state) != game_pkg::GAME_OVER)
        |-> $past(game_state) == game_pkg::PLAY)
        else $error("game over entered from a state other than play");

    blank_black: assert property (@(posedge clk) disable iff (!rst_n)
        (locked && (h >= H_ACTIVE || v >= V_ACTIVE)) |-> rgb_out == '0)
        else $error("pixel not black during blank");

endmodule

bind game_core game_core_properties #(
    .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
) properties_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .game_state (game_state),
    .hp         (hp),
    .hsync      (hsync),
    .vsync      (vsync),
    .rgb_out    (rgb_out)
);

// ==== verification/game_core_tb.sv ====
/*
 * testbench for the dodge game core on a small raster
 * raster tracker from the output syncs, directed tests, timeout
 */
`timescale 1ns/1ps

module game_core_tb;

    localparam int PERIOD    = 10;
    localparam int H_ACTIVE  = 80;
    localparam int H_FRONT   = 4;
    localparam int H_SYNC    = 8;
    localparam int H_BACK    = 8;
    localparam int V_ACTIVE  = 60;
    localparam int V_FRONT   = 2;
    localparam int V_SYNC    = 3;
    localparam int V_BACK    = 5;
    localparam int H_TOTAL   = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL   = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int FRAME     = H_TOTAL * V_TOTAL;
    localparam int TOP       = 10;
    localparam int BOTTOM    = 50;
    localparam int LEFT      = 10;
    localparam int RIGHT     = 70;
    localparam int BORDER    = 2;
    localparam int START_X   = 30;
    localparam int START_Y   = 20;
    localparam int START_W   = 20;
    localparam int START_H   = 10;
    localparam int OBS_W     = 8;
    localparam int OBS_H     = 6;
    localparam int OBS_SPEED = 4;
    localparam int NUM_WAVES = 3;
    localparam int START_HP  = 3;
    // frame ticks for one crossing of the play area
    localparam int WAVE_TICKS = (RIGHT - OBS_W - LEFT) / OBS_SPEED + 1;
    // whole victory run plus some twenty frames for the other tests
    localparam int LIMIT     = (NUM_WAVES * WAVE_TICKS + 20) * FRAME;

    localparam logic [2:0] BTN_GAME = 3'b100;
    localparam logic [2:0] BTN_MENU = 3'b010;
    localparam logic [2:0] BTN_OVER = 3'b001;

    logic                  clk;
    logic                  rst_n;
    logic                  game_button;
    logic                  menu_button;
    logic                  game_over_button;
    logic                  mouse_left;
    game_pkg::point_t      cursor;
    logic                  hsync;
    logic                  vsync;
    game_pkg::rgb_t        rgb_out;
    game_pkg::game_state_e game_state;
    game_pkg::hp_t         hp;
    logic [3:0]            wave;

    int   errors = 0;
    int   checks = 0;
    int   cycle = 0;
    int   trk_h = 0;
    int   trk_v = 0;
    logic trk_valid = 1'b0;
    logic seen_h = 1'b0;
    logic hsync_prev = 1'b0;
    logic vsync_prev = 1'b0;

    game_core #(
        .H_ACTIVE(12'(H_ACTIVE)), .H_FRONT(12'(H_FRONT)),
        .H_SYNC(12'(H_SYNC)), .H_BACK(12'(H_BACK)),
        .V_ACTIVE(12'(V_ACTIVE)), .V_FRONT(12'(V_FRONT)),
        .V_SYNC(12'(V_SYNC)), .V_BACK(12'(V_BACK)),
        .TOP_V_LINE(12'(TOP)), .BOTTOM_V_LINE(12'(BOTTOM)),
        .LEFT_H_LINE(12'(LEFT)), .RIGHT_H_LINE(12'(RIGHT)), .BORDER(12'(BORDER)),
        .START_X(12'(START_X)), .START_Y(12'(START_Y)),
        .START_W(12'(START_W)), .START_H(12'(START_H)),
        .OBS_W(12'(OBS_W)), .OBS_H(12'(OBS_H)), .OBS_SPEED(12'(OBS_SPEED)),
        .NUM_WAVES(4'(NUM_WAVES))
    ) game_core_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .game_button      (game_button),
        .menu_button      (menu_button),
        .game_over_button (game_over_button),
        .mouse_left       (mouse_left),
        .cursor           (cursor),
        .hsync            (hsync),
        .vsync            (vsync),
        .rgb_out          (rgb_out),
        .game_state       (game_state),
        .hp               (hp),
        .wave             (wave)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= LIMIT) begin
            $display("timeout: run went past %0d cycles", LIMIT);
            $display("TEST FAIL");
            $finish;
        end
    end

    // position of the pixel on rgb_out, from the sync rising edges
    always @(negedge clk) begin
        if (hsync && !hsync_prev) begin
            trk_h = H_ACTIVE + H_FRONT;
            seen_h = 1'b1;
        end else begin
            trk_h = (trk_h + 1) % H_TOTAL;
        end
        if (vsync && !vsync_prev) begin
            trk_v = V_ACTIVE + V_FRONT;
            trk_valid = seen_h;
        end else if (trk_h == 0) begin
            trk_v = (trk_v + 1) % V_TOTAL;
        end
        hsync_prev = hsync;
        vsync_prev = vsync;
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("mismatch %s: expected %0h actual %0h", name, expected, actual);
        end
    endtask

    function automatic bit in_start_box(input int x, input int y);
        return x >= START_X && x < START_X + START_W && y >= START_Y && y < START_Y + START_H;
    endfunction

    task automatic pulse_buttons(input logic [2:0] mask);
        @(posedge clk);
        game_button      <= mask[2];
        menu_button      <= mask[1];
        game_over_button <= mask[0];
        @(posedge clk);
        game_button      <= 1'b0;
        menu_button      <= 1'b0;
        game_over_button <= 1'b0;
    endtask

    task automatic move_cursor(input int x, input int y);
        @(posedge clk);
        cursor.x <= 12'(x);
        cursor.y <= 12'(y);
    endtask

    // click, then park the cursor in the screen corner
    task automatic click(input int x, input int y);
        move_cursor(x, y);
        mouse_left <= 1'b1;
        @(posedge clk);
        mouse_left <= 1'b0;
        cursor     <= '0;
    endtask

    task automatic wait_for_state(input string name, input game_pkg::game_state_e target,
                                  input int max_cycles);
        int n;
        n = 0;
        @(negedge clk);
        while (game_state != target && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        checks++;
        if (game_state != target) begin
            errors++;
            $display("%s: state %s not reached within %0d cycles", name, target.name(),
                     max_cycles);
        end
    endtask

    task automatic wait_position(input int x, input int y);
        @(negedge clk);
        #1;
        while (!(trk_valid && trk_h == x && trk_v == y)) begin
            @(negedge clk);
            #1;
        end
    endtask

    task automatic sample_pixel(input string name, input int x, input int y,
                                input game_pkg::rgb_t expected);
        wait_position(x, y);
        check(name, 32'(expected), 32'(rgb_out));
    endtask

    task automatic check_restart(input string name);
        repeat (2) @(negedge clk);
        check({name, " state"}, 32'(game_pkg::MENU), 32'(game_state));
        check({name, " hp"}, START_HP, 32'(hp));
        check({name, " wave"}, 0, 32'(wave));
    endtask

    task automatic test_reset();
        time t0;
        time t1;
        @(negedge clk);
        check("reset state", 32'(game_pkg::MENU), 32'(game_state));
        check("reset hp", START_HP, 32'(hp));
        check("reset wave", 0, 32'(wave));
        @(posedge hsync);
        t0 = $time;
        @(posedge hsync);
        t1 = $time;
        check("hsync period", H_TOTAL, 32'((t1 - t0) / PERIOD));
        @(posedge vsync);
        t0 = $time;
        @(posedge vsync);
        t1 = $time;
        check("vsync period", FRAME, 32'((t1 - t0) / PERIOD));
    endtask

    task automatic test_menu();
        int x;
        int y;
        sample_pixel("menu border", LEFT - 1, 30, game_pkg::COLOR_BORDER);
        sample_pixel("menu play area", LEFT + 5, TOP + 5, game_pkg::COLOR_MENU);
        sample_pixel("menu start box", START_X + 5, START_Y + 5, game_pkg::COLOR_START_BOX);
        sample_pixel("menu blank", H_ACTIVE + 10, 30, 12'h000);
        for (int i = 0; i < 6; i++) begin
            x = START_X;
            y = START_Y;
            while (in_start_box(x, y)) begin
                x = $urandom % H_ACTIVE;
                y = $urandom % V_ACTIVE;
            end
            click(x, y);
            repeat (2) @(negedge clk);
            check("click outside start box", 32'(game_pkg::MENU), 32'(game_state));
        end
        x = START_X + $urandom % START_W;
        y = START_Y + $urandom % START_H;
        click(x, y);
        wait_for_state("click in start box", game_pkg::PLAY, 2);
    endtask

    task automatic test_victory();
        int c0;
        int frames;
        c0 = cycle;
        wait_for_state("waves to victory", game_pkg::VICTORY,
                       (NUM_WAVES * WAVE_TICKS + 2) * FRAME);
        frames = (cycle - c0) / FRAME;
        checks++;
        if (frames < NUM_WAVES * WAVE_TICKS - 1 || frames > NUM_WAVES * WAVE_TICKS) begin
            errors++;
            $display("victory came after %0d frames, expected about %0d", frames,
                     NUM_WAVES * WAVE_TICKS);
        end
        check("victory wave", NUM_WAVES, 32'(wave));
        check("victory hp", START_HP, 32'(hp));
        sample_pixel("victory play area", LEFT + 5, TOP + 5, game_pkg::COLOR_VICTORY);
    endtask

    task automatic test_collision();
        int k;
        int hp_exp;
        int lane_y;
        lane_y = TOP + int'(game_pkg::LANE_OFFSET[0]) + 1;
        pulse_buttons(BTN_MENU);
        wait_for_state("menu from victory", game_pkg::MENU, 2);
        check_restart("menu from victory");
        move_cursor(LEFT + 1, lane_y);
        // start well away from the frame tick
        wait_position(0, 20);
        pulse_buttons(BTN_GAME);
        wait_for_state("collision start", game_pkg::PLAY, 2);
        hp_exp = START_HP;
        k = 0;
        while (hp_exp > 0) begin
            // just past a frame tick, as seen at the output
            wait_position(5, V_ACTIVE);
            k++;
            hp_exp--;
            check("collision hp", hp_exp, 32'(hp));
            move_cursor(LEFT + k * OBS_SPEED + 1, lane_y);
            // obstacle drawn where the cursor now sits
            if (hp_exp > 0) begin
                sample_pixel("collision obstacle", LEFT + k * OBS_SPEED + 1, lane_y,
                             game_pkg::COLOR_OBSTACLE);
            end
        end
        wait_for_state("collision game over", game_pkg::GAME_OVER, 2);
        check("collision wave", 0, 32'(wave));
        move_cursor(0, 0);
    endtask

    task automatic test_buttons();
        pulse_buttons(BTN_MENU);
        wait_for_state("menu from game over", game_pkg::MENU, 2);
        check_restart("menu from game over");
        pulse_buttons(BTN_GAME);
        wait_for_state("game button", game_pkg::PLAY, 2);
        pulse_buttons(BTN_OVER);
        wait_for_state("game over button", game_pkg::GAME_OVER, 2);
        pulse_buttons(BTN_MENU);
        wait_for_state("menu after game over button", game_pkg::MENU, 2);
        pulse_buttons(BTN_GAME);
        wait_for_state("second start", game_pkg::PLAY, 2);
        pulse_buttons(BTN_MENU);
        wait_for_state("menu from play", game_pkg::MENU, 2);
        check_restart("menu from play");
    endtask

    initial begin
        void'($urandom(32'h794d));
        rst_n            = 1'b0;
        game_button      = 1'b0;
        menu_button      = 1'b0;
        game_over_button = 1'b0;
        mouse_left       = 1'b0;
        cursor           = '0;
        repeat (7) @(posedge clk);
        @(negedge clk);
        check("reset hsync", 0, 32'(hsync));
        check("reset vsync", 0, 32'(vsync));
        check("reset rgb", 0, 32'(rgb_out));
        @(posedge clk);
        rst_n <= 1'b1;

        test_reset();
        test_menu();
        test_victory();
        test_collision();
        test_buttons();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
